// File: Makefile
# Verilator simulation of the ASIC DAQ controller
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f --top-module asic_daq_tb -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: common/asic_daq_config.svh
`ifndef ASIC_DAQ_CONFIG_SVH
`define ASIC_DAQ_CONFIG_SVH

// host bus addressing
`define BANK_BITS 3 // eight banks
`define REG_BITS 4 // sixteen registers per bank
`define BUS_DATA_WIDTH 32

// readout path
`define ASIC_WORD_WIDTH 16
`define FIFO_DEPTH_LOG2 4 // 16 words
`define ERROR_COUNT_WIDTH 8

// command outputs
`define TRIGGER_COUNT_WIDTH 8
`define DRESET_CYCLES 8 // dreset high time in sysclk cycles

`endif

// File: common/asic_daq_pkg.sv
`default_nettype none

`include "asic_daq_config.svh"

package asic_daq_pkg;

	// bank number from the upper address bits
	typedef enum logic [`BANK_BITS-1:0] {
		BANK_SETTINGS = 3'd0,
		BANK_STATUS   = 3'd1,
		BANK_PULSE    = 3'd2, // write fires a one-cycle command
		BANK_FIFO     = 3'd5, // read pops a readout word
		BANK_COUNTERS = 3'd6
	} bank_e;

	// register numbers within the pulse bank
	typedef enum logic [`REG_BITS-1:0] {
		CMD_DRESET  = 4'd0,
		CMD_TRIGGER = 4'd3
	} cmd_e;

	// serial deserializer
	typedef enum logic {
		RX_IDLE  = 1'b0,
		RX_SHIFT = 1'b1
	} readout_state_e;

endpackage

`default_nettype wire

// File: host_bus/host_bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module host_bus_decoder (
	input wire sysclk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [`BANK_BITS+`REG_BITS-1:0] wb_adr,
	input wire [`BUS_DATA_WIDTH-1:0] wb_dat_w,
	output logic [`BUS_DATA_WIDTH-1:0] wb_dat_r,
	output logic wb_ack,
	output asic_daq_pkg::bank_e bank,
	output logic [`REG_BITS-1:0] reg_addr,
	output logic [`BUS_DATA_WIDTH-1:0] write_data,
	input wire [`BUS_DATA_WIDTH-1:0] read_data,
	output logic [(1<<`BANK_BITS)-1:0] write_strobe,
	output logic [(1<<`BANK_BITS)-1:0] read_strobe
);
	import asic_daq_pkg::*;

	localparam int NUM_BANKS = 1 << `BANK_BITS;

	logic new_cycle;
	logic [NUM_BANKS-1:0] bank_onehot;

	// master holds address and data until it has seen ack
	assign bank = bank_e'(wb_adr[`REG_BITS +: `BANK_BITS]);
	assign reg_addr = wb_adr[`REG_BITS-1:0];
	assign write_data = wb_dat_w;

	assign new_cycle = wb_cyc && wb_stb && !wb_ack; // ack low marks a fresh request
	assign bank_onehot = NUM_BANKS'(1) << bank;

	// ----------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			write_strobe <= '0;
			read_strobe <= '0;
		end else begin
			wb_ack <= new_cycle; // exactly one wait cycle
			write_strobe <= (new_cycle && wb_we) ? bank_onehot : '0;
			read_strobe <= (new_cycle && !wb_we) ? bank_onehot : '0;
		end
	end

	// sampled before the strobe side effects land
	always_ff @(posedge sysclk) begin
		if (new_cycle) begin
			wb_dat_r <= read_data;
		end
	end

endmodule

`default_nettype wire

// File: host_bus/register_banks.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module register_banks (
	input wire sysclk,
	input wire reset,
	input wire asic_daq_pkg::bank_e bank,
	input wire [`REG_BITS-1:0] reg_addr,
	input wire [`BUS_DATA_WIDTH-1:0] write_data,
	input wire [(1<<`BANK_BITS)-1:0] write_strobe,
	input wire [(1<<`BANK_BITS)-1:0] read_strobe,
	output logic [`BUS_DATA_WIDTH-1:0] read_data,
	output logic readout_enable,
	output logic [(1<<`REG_BITS)-1:0] cmd_pulse,
	input wire [7:0] flags,
	input wire [`TRIGGER_COUNT_WIDTH-1:0] trigger_count,
	input wire [`ASIC_WORD_WIDTH-1:0] fifo_head,
	input wire fifo_empty,
	input wire [`ERROR_COUNT_WIDTH-1:0] fifo_errors,
	input wire word_valid,
	output logic [7:0] status_led
);
	import asic_daq_pkg::*;

	localparam int NUM_BANKS = 1 << `BANK_BITS;
	localparam int NUM_REGS = 1 << `REG_BITS;

	logic [`BUS_DATA_WIDTH-1:0] settings [NUM_REGS];
	logic [`BUS_DATA_WIDTH-1:0] access_count [NUM_REGS]; // reads 0-7, then writes 8-15
	logic [`BUS_DATA_WIDTH-1:0] words_received;
	logic [`BUS_DATA_WIDTH-1:0] status_word;

	assign readout_enable = settings[0][0];
	assign status_led = flags;
	// register number of a pulse bank write selects the command bit
	assign cmd_pulse = write_strobe[BANK_PULSE] ? (NUM_REGS'(1) << reg_addr) : '0;

	// ----------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) settings[i] <= '0;
		end else if (write_strobe[BANK_SETTINGS]) begin
			settings[reg_addr] <= write_data;
		end
	end

	// counts every bank, mapped or not
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) access_count[i] <= '0;
			words_received <= '0;
		end else begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (read_strobe[i]) access_count[i] <= access_count[i] + 1;
				if (write_strobe[i]) access_count[NUM_BANKS+i] <= access_count[NUM_BANKS+i] + 1;
			end
			if (word_valid) words_received <= words_received + 1; // dropped words too
		end
	end

	// ----------------------------------------
	always_comb begin
		status_word = '0;
		case (reg_addr)
			4'd0: status_word[7:0] = flags;
			4'd1: status_word[`TRIGGER_COUNT_WIDTH-1:0] = trigger_count;
			4'd2: status_word[0] = fifo_empty;
			4'd3: status_word[`ERROR_COUNT_WIDTH-1:0] = fifo_errors;
			4'd4: status_word = words_received;
			default: status_word = '0;
		endcase
	end

	always_comb begin
		read_data = '0;
		case (bank)
			BANK_SETTINGS: read_data = settings[reg_addr];
			BANK_STATUS: read_data = status_word;
			BANK_FIFO: if (!fifo_empty) read_data = `BUS_DATA_WIDTH'(fifo_head); // head before pop
			BANK_COUNTERS: read_data = access_count[reg_addr];
			default: read_data = '0; // pulse bank and banks 3, 4, 7
		endcase
	end

endmodule

`default_nettype wire

// File: readout/serial_word_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module serial_word_deserializer (
	input wire sysclk,
	input wire reset,
	input wire serial_in,
	input wire readout_enable,
	output logic [`ASIC_WORD_WIDTH-1:0] word,
	output logic word_valid
);
	import asic_daq_pkg::*;

	localparam int BIT_COUNT_BITS = $clog2(`ASIC_WORD_WIDTH);
	localparam logic [BIT_COUNT_BITS-1:0] LAST_BIT = BIT_COUNT_BITS'(`ASIC_WORD_WIDTH - 1);

	readout_state_e state;
	logic [BIT_COUNT_BITS-1:0] bit_count;
	logic [`ASIC_WORD_WIDTH-1:0] shift_reg;

	assign word = shift_reg; // only meaningful while word_valid

	// ----------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= RX_IDLE;
			bit_count <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (serial_in && readout_enable) begin // start bit
						state <= RX_SHIFT;
						bit_count <= '0;
					end
				end
				RX_SHIFT: begin
					bit_count <= bit_count + BIT_COUNT_BITS'(1);
					if (bit_count == LAST_BIT) begin
						state <= RX_IDLE;
						word_valid <= 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// msb arrives first
	always_ff @(posedge sysclk) begin
		if (state == RX_SHIFT) begin
			shift_reg <= {shift_reg[`ASIC_WORD_WIDTH-2:0], serial_in};
		end
	end

endmodule

`default_nettype wire

// File: readout/word_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module word_fifo (
	input wire sysclk,
	input wire reset,
	input wire push,
	input wire [`ASIC_WORD_WIDTH-1:0] push_data,
	input wire pop,
	output logic [`ASIC_WORD_WIDTH-1:0] head,
	output logic empty,
	output logic [`ERROR_COUNT_WIDTH-1:0] error_count
);
	localparam int PTR_BITS = `FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << PTR_BITS;
	localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS+1)'(DEPTH);

	logic [`ASIC_WORD_WIDTH-1:0] mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] occupancy;
	logic full;
	logic do_push;
	logic do_pop;
	logic error_hit;

	assign empty = (occupancy == '0);
	assign full = (occupancy == FULL_COUNT);
	assign head = mem[rd_ptr]; // first word falls through
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign error_hit = (push && full) || (pop && empty); // overflow or underflow

	always_ff @(posedge sysclk) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

	// ----------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
			error_count <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + PTR_BITS'(1);
			if (do_pop) rd_ptr <= rd_ptr + PTR_BITS'(1);
			occupancy <= occupancy + (PTR_BITS+1)'(do_push) - (PTR_BITS+1)'(do_pop);
			if (error_hit && error_count != '1) begin
				error_count <= error_count + `ERROR_COUNT_WIDTH'(1); // sticks at max
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/asic_daq_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module asic_daq_top (
	input wire sysclk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [`BANK_BITS+`REG_BITS-1:0] wb_adr,
	input wire [`BUS_DATA_WIDTH-1:0] wb_dat_w,
	output logic [`BUS_DATA_WIDTH-1:0] wb_dat_r,
	output logic wb_ack,
	input wire serial_in,
	output logic dreset,
	output logic trigger_out,
	output logic [7:0] status_led
);
	import asic_daq_pkg::*;

	bank_e bank;
	logic [`REG_BITS-1:0] reg_addr;
	logic [`BUS_DATA_WIDTH-1:0] write_data;
	logic [`BUS_DATA_WIDTH-1:0] read_data;
	logic [(1<<`BANK_BITS)-1:0] write_strobe;
	logic [(1<<`BANK_BITS)-1:0] read_strobe;
	logic [(1<<`REG_BITS)-1:0] cmd_pulse; // one bit per pulse bank register
	logic [7:0] flags;
	logic [`TRIGGER_COUNT_WIDTH-1:0] trigger_count;
	logic readout_enable;
	logic [`ASIC_WORD_WIDTH-1:0] word;
	logic word_valid;
	logic [`ASIC_WORD_WIDTH-1:0] fifo_head;
	logic fifo_empty;
	logic [`ERROR_COUNT_WIDTH-1:0] fifo_errors;

	// ----------------------------------------
	host_bus_decoder host_bus_decoder_inst (.sysclk(sysclk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.bank(bank), .reg_addr(reg_addr), .write_data(write_data), .read_data(read_data),
		.write_strobe(write_strobe), .read_strobe(read_strobe));

	register_banks register_banks_inst (.sysclk(sysclk), .reset(reset),
		.bank(bank), .reg_addr(reg_addr), .write_data(write_data),
		.write_strobe(write_strobe), .read_strobe(read_strobe), .read_data(read_data),
		.readout_enable(readout_enable), .cmd_pulse(cmd_pulse), .flags(flags),
		.trigger_count(trigger_count), .fifo_head(fifo_head), .fifo_empty(fifo_empty),
		.fifo_errors(fifo_errors), .word_valid(word_valid), .status_led(status_led));

	// ----------------------------------------
	command_sequencer command_sequencer_inst (.sysclk(sysclk), .reset(reset),
		.cmd_pulse(cmd_pulse), .dreset(dreset), .trigger_out(trigger_out),
		.flags(flags), .trigger_count(trigger_count));

	// ----------------------------------------
	serial_word_deserializer serial_word_deserializer_inst (.sysclk(sysclk), .reset(reset),
		.serial_in(serial_in), .readout_enable(readout_enable),
		.word(word), .word_valid(word_valid));

	word_fifo word_fifo_inst (.sysclk(sysclk), .reset(reset),
		.push(word_valid), .push_data(word),
		.pop(read_strobe[BANK_FIFO]), // each bank 5 read pops one word
		.head(fifo_head), .empty(fifo_empty), .error_count(fifo_errors));

endmodule

`default_nettype wire

// File: rtl/command_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module command_sequencer (
	input wire sysclk,
	input wire reset,
	input wire [(1<<`REG_BITS)-1:0] cmd_pulse,
	output logic dreset,
	output logic trigger_out,
	output logic [7:0] flags,
	output logic [`TRIGGER_COUNT_WIDTH-1:0] trigger_count
);
	import asic_daq_pkg::*;

	localparam int DRESET_COUNT_BITS = $clog2(`DRESET_CYCLES + 1);
	localparam logic [DRESET_COUNT_BITS-1:0] DRESET_START = DRESET_COUNT_BITS'(`DRESET_CYCLES);

	logic [DRESET_COUNT_BITS-1:0] dreset_remaining;
	logic dreset_occurred;
	logic trigger_occurred;

	assign dreset = (dreset_remaining != '0);
	// dreset seen in bit 3 and trigger seen in bit 0
	assign flags = {4'b0000, dreset_occurred, 2'b00, trigger_occurred};

	always_ff @(posedge sysclk) begin
		if (reset) begin
			trigger_out <= 1'b0;
			trigger_occurred <= 1'b0;
			trigger_count <= '0;
			dreset_occurred <= 1'b0;
			dreset_remaining <= '0;
		end else begin
			trigger_out <= cmd_pulse[CMD_TRIGGER]; // one cycle after ack
			if (cmd_pulse[CMD_TRIGGER]) begin
				trigger_occurred <= 1'b1;
				trigger_count <= trigger_count + `TRIGGER_COUNT_WIDTH'(1); // wraps
			end
			if (cmd_pulse[CMD_DRESET]) begin
				dreset_remaining <= DRESET_START; // restarts a running pulse
				dreset_occurred <= 1'b1;
			end else if (dreset) begin
				dreset_remaining <= dreset_remaining - DRESET_COUNT_BITS'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: test/asic_daq_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module asic_daq_props (
	input wire sysclk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire trigger_out,
	input wire dreset
);
	// ----------------------------------------
	ack_in_cycle: assert property (@(posedge sysclk) disable iff (reset)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack high outside a bus cycle");

	ack_single: assert property (@(posedge sysclk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held longer than one cycle");

	// ----------------------------------------
	trigger_single: assert property (@(posedge sysclk) disable iff (reset)
		trigger_out |=> !trigger_out)
		else $error("trigger_out held longer than one cycle");

	dreset_width: assert property (@(posedge sysclk) disable iff (reset)
		$rose(dreset) |-> dreset [*`DRESET_CYCLES] ##1 !dreset)
		else $error("dreset pulse width differs from the configured cycle count");

endmodule

bind asic_daq_top asic_daq_props asic_daq_props_inst (
	.sysclk(sysclk),
	.reset(reset),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.trigger_out(trigger_out),
	.dreset(dreset)
);

`default_nettype wire

// File: test/asic_daq_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "asic_daq_config.svh"

module asic_daq_tb;
	import asic_daq_pkg::*;

	localparam int CYCLE_LIMIT = 6000; // tests take roughly 800 cycles
	localparam int ADR_BITS = `BANK_BITS + `REG_BITS;
	localparam int FIFO_WORDS = 1 << `FIFO_DEPTH_LOG2;

	logic sysclk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADR_BITS-1:0] wb_adr;
	logic [`BUS_DATA_WIDTH-1:0] wb_dat_w;
	logic [`BUS_DATA_WIDTH-1:0] wb_dat_r;
	logic wb_ack;
	logic serial_in;
	logic dreset;
	logic trigger_out;
	logic [7:0] status_led;

	// shadow of the DUT state
	logic [`BUS_DATA_WIDTH-1:0] shadow_settings [16];
	int shadow_reads [8];
	int shadow_writes [8];
	logic [`ASIC_WORD_WIDTH-1:0] shadow_fifo [$];
	int shadow_errors;
	int shadow_words;
	int shadow_triggers;
	logic shadow_trig_seen;
	logic shadow_dreset_seen;
	logic [15:0] lfsr_state;

	// reads waiting for the compare process
	logic [ADR_BITS-1:0] adr_q [$];
	logic [`BUS_DATA_WIDTH-1:0] exp_q [$];
	logic [`BUS_DATA_WIDTH-1:0] got_q [$];

	int read_mismatches = 0;
	int mismatch_mark;
	int direct_errors;
	int total_errors;
	int tests_run;
	int tests_failed;
	int trigger_pulses = 0;
	int cycle_count = 0;

	tb_clock_gen tb_clock_gen_inst (.sysclk(sysclk), .reset(reset));

	asic_daq_top asic_daq_top_inst (.sysclk(sysclk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.serial_in(serial_in), .dreset(dreset), .trigger_out(trigger_out),
		.status_led(status_led));

	// ----------------------------------------
	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] expected_value(input logic [2:0] bank,
			input logic [3:0] regn);
		logic [31:0] value;
		value = '0;
		case (bank)
			BANK_SETTINGS: value = shadow_settings[regn];
			BANK_STATUS: begin
				case (regn)
					4'd0: value = {28'd0, shadow_dreset_seen, 2'b00, shadow_trig_seen};
					4'd1: value = 32'(shadow_triggers % 256);
					4'd2: value = {31'd0, shadow_fifo.size() == 0};
					4'd3: value = 32'(shadow_errors);
					4'd4: value = 32'(shadow_words);
					default: value = '0;
				endcase
			end
			BANK_FIFO: if (shadow_fifo.size() > 0) value = {16'd0, shadow_fifo[0]};
			BANK_COUNTERS: begin
				if (regn < 4'd8) value = 32'(shadow_reads[regn[2:0]]);
				else value = 32'(shadow_writes[regn[2:0]]);
			end
			default: value = '0; // pulse bank and unmapped banks
		endcase
		return value;
	endfunction

	task automatic note_fifo_error;
		if (shadow_errors < 255) shadow_errors = shadow_errors + 1;
	endtask

	// ----------------------------------------
	task automatic bus_write(input logic [2:0] bank, input logic [3:0] regn,
			input logic [31:0] data);
		@(posedge sysclk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= {bank, regn};
		wb_dat_w <= data;
		@(posedge sysclk);
		while (wb_ack !== 1'b1) @(posedge sysclk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		shadow_writes[bank] = shadow_writes[bank] + 1;
		if (bank == BANK_SETTINGS) shadow_settings[regn] = data;
		if (bank == BANK_PULSE && regn == CMD_TRIGGER) begin
			shadow_triggers = shadow_triggers + 1;
			shadow_trig_seen = 1'b1;
		end
		if (bank == BANK_PULSE && regn == CMD_DRESET) shadow_dreset_seen = 1'b1;
	endtask

	task automatic bus_read(input logic [2:0] bank, input logic [3:0] regn);
		logic [31:0] expected;
		expected = expected_value(bank, regn); // value before this read's side effect
		@(posedge sysclk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= {bank, regn};
		@(posedge sysclk);
		while (wb_ack !== 1'b1) @(posedge sysclk);
		adr_q.push_back({bank, regn});
		exp_q.push_back(expected);
		got_q.push_back(wb_dat_r);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		shadow_reads[bank] = shadow_reads[bank] + 1;
		if (bank == BANK_FIFO) begin
			if (shadow_fifo.size() > 0) void'(shadow_fifo.pop_front());
			else note_fifo_error();
		end
	endtask

	// start bit, then 16 data bits msb first
	task automatic send_frame(input logic [15:0] data);
		@(posedge sysclk);
		serial_in <= 1'b1;
		for (int i = 15; i >= 0; i--) begin
			@(posedge sysclk);
			serial_in <= data[i];
		end
		@(posedge sysclk);
		serial_in <= 1'b0;
		repeat (3) @(posedge sysclk);
		if (shadow_settings[0][0]) begin
			shadow_words = shadow_words + 1;
			if (shadow_fifo.size() < FIFO_WORDS) shadow_fifo.push_back(data);
			else note_fifo_error();
		end
	endtask

	task automatic finish_test(input string name);
		int errors;
		repeat (2) @(posedge sysclk); // lets the compare process drain
		errors = read_mismatches - mismatch_mark + direct_errors;
		mismatch_mark = read_mismatches;
		direct_errors = 0;
		tests_run = tests_run + 1;
		total_errors = total_errors + errors;
		if (errors == 0) begin
			$display("test %-10s ok", name);
		end else begin
			$display("test %-10s %0d errors", name, errors);
			tests_failed = tests_failed + 1;
		end
	endtask

	// ----------------------------------------
	always @(posedge sysclk) begin
		while (got_q.size() > 0) begin
			if (got_q[0] !== exp_q[0]) begin
				$display("CHECK FAILED wb_dat_r bank %0d reg %0d: got 0x%08h expected 0x%08h",
					adr_q[0][6:4], adr_q[0][3:0], got_q[0], exp_q[0]);
				read_mismatches = read_mismatches + 1;
			end
			void'(adr_q.pop_front());
			void'(exp_q.pop_front());
			void'(got_q.pop_front());
		end
	end

	always @(posedge sysclk) begin
		if (trigger_out === 1'b1) trigger_pulses = trigger_pulses + 1;
	end

	always @(posedge sysclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	// ----------------------------------------
	initial begin
		int pulses_before;
		int high_cycles;
		logic [7:0] expected_led;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_dat_w <= '0;
		serial_in <= 1'b0;
		for (int i = 0; i < 16; i++) shadow_settings[i] = '0;
		for (int i = 0; i < 8; i++) begin
			shadow_reads[i] = 0;
			shadow_writes[i] = 0;
		end
		shadow_errors = 0;
		shadow_words = 0;
		shadow_triggers = 0;
		shadow_trig_seen = 1'b0;
		shadow_dreset_seen = 1'b0;
		lfsr_state = 16'h0001;
		mismatch_mark = 0;
		direct_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		@(posedge sysclk);
		while (reset !== 1'b0) @(posedge sysclk);

		for (int r = 0; r < 16; r++) bus_write(BANK_SETTINGS, 4'(r), random_bits(32));
		for (int r = 0; r < 16; r++) bus_read(BANK_SETTINGS, 4'(r));
		bus_read(3'd3, 4'd0);
		bus_read(3'd4, 4'd5);
		bus_read(3'd7, 4'd15);
		finish_test("settings");

		pulses_before = trigger_pulses;
		repeat (3) bus_write(BANK_PULSE, CMD_TRIGGER, random_bits(32)); // data ignored
		repeat (2) @(posedge sysclk);
		if (trigger_pulses - pulses_before != 3) begin
			$display("trigger_out pulsed %0d times for 3 trigger commands",
				trigger_pulses - pulses_before);
			direct_errors = direct_errors + 1;
		end
		bus_read(BANK_STATUS, 4'd1);
		expected_led = {4'd0, shadow_dreset_seen, 2'b00, shadow_trig_seen};
		if (status_led !== expected_led) begin
			$display("CHECK FAILED status_led: got 0x%02h expected 0x%02h",
				status_led, expected_led);
			direct_errors = direct_errors + 1;
		end
		finish_test("trigger");

		bus_write(BANK_PULSE, CMD_DRESET, 32'd0);
		high_cycles = 0;
		for (int c = 0; c < 2 * `DRESET_CYCLES; c++) begin
			@(posedge sysclk);
			if (c == 0 && dreset !== 1'b1) begin
				$display("dreset did not go high on the cycle after ack");
				direct_errors = direct_errors + 1;
			end
			if (dreset === 1'b1) high_cycles = high_cycles + 1;
		end
		if (high_cycles != `DRESET_CYCLES) begin
			$display("CHECK FAILED dreset high cycles: got 0x%0h expected 0x%0h",
				high_cycles, `DRESET_CYCLES);
			direct_errors = direct_errors + 1;
		end
		bus_read(BANK_STATUS, 4'd0);
		finish_test("dreset");

		bus_write(BANK_SETTINGS, 4'd0, 32'd1); // readout_enable on
		repeat (5) send_frame(16'(random_bits(16)));
		repeat (5) bus_read(BANK_FIFO, 4'd0);
		bus_read(BANK_STATUS, 4'd4);
		bus_read(BANK_STATUS, 4'd2);
		bus_write(BANK_SETTINGS, 4'd0, 32'd0);
		send_frame(16'(random_bits(16)));
		bus_read(BANK_STATUS, 4'd4);
		bus_read(BANK_STATUS, 4'd2);
		finish_test("readout");

		bus_write(BANK_SETTINGS, 4'd0, 32'd1);
		repeat (FIFO_WORDS + 2) send_frame(16'(random_bits(16)));
		repeat (FIFO_WORDS + 1) bus_read(BANK_FIFO, 4'd0); // last one underflows
		bus_read(BANK_STATUS, 4'd3);
		finish_test("overflow");

		for (int r = 0; r < 16; r++) bus_read(BANK_COUNTERS, 4'(r));
		finish_test("counters");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic sysclk,
	output logic reset
);
	initial begin
		sysclk = 1'b0;
		forever #10 sysclk = ~sysclk; // 20 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge sysclk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/asic_daq_pkg.sv
host_bus/host_bus_decoder.sv
host_bus/register_banks.sv
rtl/command_sequencer.sv
readout/serial_word_deserializer.sv
readout/word_fifo.sv
rtl/asic_daq_top.sv
test/tb_clock_gen.sv
test/asic_daq_props.sv
test/asic_daq_tb.sv
